/* sources.f */
+incdir+design
design/can_pkg.sv
design/can_crc15.sv
design/can_tx.sv
design/can_rx.sv
design/can_drive_link.sv
tb/tb_can_drive_link.sv

/* Bender.yml */
package:
  name: can_drive_link

sources:
  - include_dirs:
      - design
    files:
      - design/can_pkg.sv
      - design/can_crc15.sv
      - design/can_tx.sv
      - design/can_rx.sv
      - design/can_drive_link.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_can_drive_link.sv

/* tb/tb_can_drive_link.sv */
`timescale 1ns/1ps
`default_nettype none
`include "can_cfg.svh"

module tb_can_drive_link;

    localparam int BIT_CYCLES = 8;
    localparam int PERIOD = 3000;
    localparam int FRAMES = 8;
    localparam int TIMEOUT_PERIODS = 12;
    localparam int CLK_NS = 40;
    localparam int SEED = 32'h720a;

    localparam int KIND_VALID = 0;
    localparam int KIND_WRONG_ID = 1;
    localparam int KIND_SHORT = 2;
    localparam int KIND_BAD_CRC = 3;

    logic clk = 1'b0;
    logic rst_n;
    logic enable;
    logic [31:0] velocity;
    logic drive;  // testbench side of the open-drain bus.
    wire logic bus;
    wire logic tx;
    wire logic [31:0] position;
    wire logic [15:0] power;
    wire logic [7:0] temp;
    wire logic [3:0] state;
    wire logic traj;
    wire logic mot;
    wire logic enc;
    wire logic ctrl;

    integer seed;
    int errors = 0;
    int cycle = 0;

    // expected state of the node.
    logic cmd_enable;
    logic [31:0] cmd_velocity;
    logic [31:0] exp_position = '0;
    logic [15:0] exp_power = '0;
    logic [7:0] exp_temp = '0;
    logic [3:0] exp_flags = '0;  // traj, mot, enc, ctrl.
    logic [3:0] exp_state = '0;

    // reference frame, raw bits in bus order.
    logic [191:0] raw_bits;
    int raw_len;
    int ack_index;

    // last frame seen from the node.
    logic [10:0] cap_id;
    logic [3:0] cap_dlc;
    logic [31:0] cap_data;  // first byte on top.
    logic cap_crc_ok;
    int cap_start;

    assign bus = tx & drive;

    always #(CLK_NS / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    can_drive_link #(
        .BIT_DIVIDER(BIT_CYCLES),
        .TX_PERIOD(PERIOD)
    ) UUT (
        .clk(clk),
        .rst_n(rst_n),
        .rx(bus),
        .tx(tx),
        .enable(enable),
        .velocity(velocity),
        .position(position),
        .power(power),
        .temp(temp),
        .state(state),
        .traj(traj),
        .mot(mot),
        .enc(enc),
        .ctrl(ctrl)
    );

    task automatic log_error(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    function automatic logic [14:0] crc15_over(input logic [127:0] bits, input int count);
        logic [14:0] r;
        logic fb;
        r = 15'd0;
        for (int i = 0; i < count; i++) begin
            fb = bits[i] ^ r[14];
            r = {r[13:0], 1'b0};
            if (fb) r = r ^ 15'h4599;
        end
        return r;
    endfunction

    //////////////////////////////
    // output checks
    //////////////////////////////

    task automatic check_quiet(input string when);
        assert (tx === 1'b1 && position === '0 && power === '0 && temp === '0 &&
                state === '0 && {traj, mot, enc, ctrl} === 4'b0000)
        else log_error($sformatf("%s: tx or status outputs not idle", when));
    endtask

    task automatic check_outputs(input string when);
        assert ({position, power, temp, traj, mot, enc, ctrl, state} ===
                {exp_position, exp_power, exp_temp, exp_flags, exp_state})
        else log_error($sformatf("%s: pos %h pwr %h temp %h flags %b state %h, expected %h %h %h %b %h",
                                 when, position, power, temp, {traj, mot, enc, ctrl}, state,
                                 exp_position, exp_power, exp_temp, exp_flags, exp_state));
    endtask

    // tx never goes unknown once reset is over.
    always @(negedge clk) begin
        if (rst_n) begin
            assert (tx === 1'b0 || tx === 1'b1) else log_error("tx is unknown");
        end
    end

    //////////////////////////////
    // frame builder and sender
    //////////////////////////////

    task automatic build_frame(input logic [10:0] fid, input logic [3:0] fdlc,
                               input logic [63:0] fdata, input logic corrupt);
        logic [127:0] bits;
        logic [14:0] crc;
        logic last;
        int n;
        int run;
        bits = '0;
        n = 1;  // start bit is dominant.
        for (int i = 10; i >= 0; i--) begin
            bits[n] = fid[i];
            n++;
        end
        n = n + 3;  // rtr, ide and r0 all dominant.
        for (int i = 3; i >= 0; i--) begin
            bits[n] = fdlc[i];
            n++;
        end
        for (int i = 0; i < fdlc * 8; i++) begin
            bits[n] = fdata[63 - i];
            n++;
        end
        crc = crc15_over(bits, n);
        if (corrupt) crc[0] = ~crc[0];
        for (int i = 14; i >= 0; i--) begin
            bits[n] = crc[i];
            n++;
        end
        raw_len = 0;
        run = 0;
        last = 1'b1;
        for (int i = 0; i < n; i++) begin
            raw_bits[raw_len] = bits[i];
            raw_len++;
            run = (i > 0 && bits[i] == last) ? run + 1 : 1;
            last = bits[i];
            if (run == 5) begin
                raw_bits[raw_len] = ~last;  // stuff bit.
                raw_len++;
                last = ~last;
                run = 1;
            end
        end
        ack_index = raw_len + 1;
        for (int i = 0; i < 10; i++) begin
            raw_bits[raw_len] = 1'b1;  // delimiters, ack slot and eof.
            raw_len++;
        end
    endtask

    task automatic send_frame(output logic ack_level);
        ack_level = 1'b1;
        for (int i = 0; i < raw_len; i++) begin
            @(posedge clk);
            drive <= raw_bits[i];
            repeat (5) @(negedge clk);  // mid-bit.
            if (i == ack_index) begin
                ack_level = bus;
            end else begin
                assert (bus === raw_bits[i])
                else log_error($sformatf("bus bit %0d is %b while sending %b", i, bus, raw_bits[i]));
            end
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic send_status(input int kind);
        logic [63:0] payload;
        logic [10:0] sid;
        logic [3:0] sdlc;
        logic ack_level;
        for (int i = 0; i < 8; i++) begin
            payload[63 - 8*i -: 8] = $random(seed);
        end
        sid = (kind == KIND_WRONG_ID) ? (`CAN_STATUS_ID ^ 11'h040) : `CAN_STATUS_ID;
        sdlc = (kind == KIND_SHORT) ? 4'd4 : 4'd8;
        build_frame(sid, sdlc, payload, kind == KIND_BAD_CRC);
        send_frame(ack_level);
        assert (ack_level === (kind == KIND_BAD_CRC))
        else log_error($sformatf("status kind %0d: ack slot level %b", kind, ack_level));
        if (kind == KIND_VALID) begin
            exp_position = {payload[39:32], payload[47:40], payload[55:48], payload[63:56]};
            exp_power = {payload[23:16], payload[31:24]};
            exp_temp = payload[15:8];
            exp_flags = payload[7:4];
            exp_state = payload[3:0];
        end
        repeat (2) @(negedge clk);
        check_outputs($sformatf("after status kind %0d", kind));
    endtask

    //////////////////////////////
    // bus monitor
    //////////////////////////////

    task automatic capture_frame();
        logic [127:0] bits;
        logic [14:0] rx_crc;
        logic last;
        logic b;
        int n;
        int need;
        int run;
        int dlc_n;
        @(negedge clk);
        while (bus !== 1'b0) @(negedge clk);
        cap_start = cycle;
        repeat (4) @(negedge clk);
        bits = '0;
        bits[0] = bus;
        n = 1;
        run = 1;
        last = bus;
        need = 19;
        dlc_n = 0;
        while (n < need) begin
            repeat (BIT_CYCLES) @(negedge clk);
            b = bus;
            if (run == 5) begin
                assert (b !== last) else log_error("six equal bits in a row in command frame");
                run = 1;
                last = b;
            end else begin
                bits[n] = b;
                n++;
                run = (b === last) ? run + 1 : 1;
                last = b;
                if (n == 19) begin
                    dlc_n = {bits[15], bits[16], bits[17], bits[18]};
                    if (dlc_n > 8) dlc_n = 8;
                    need = 34 + 8 * dlc_n;
                end
            end
        end
        if (run == 5) begin
            repeat (BIT_CYCLES) @(negedge clk);
            assert (bus !== last) else log_error("six equal bits at end of crc");
        end
        // crc delimiter, ack slot, ack delimiter, eof.
        for (int i = 0; i < 10; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            if (i != 1) begin
                assert (bus === 1'b1) else log_error($sformatf("frame tail bit %0d dominant", i));
            end
        end
        for (int i = 0; i < 11; i++) cap_id[10 - i] = bits[1 + i];
        cap_dlc = {bits[15], bits[16], bits[17], bits[18]};
        cap_data = '0;
        for (int i = 0; i < 8 * dlc_n && i < 32; i++) cap_data[31 - i] = bits[19 + i];
        for (int i = 0; i < 15; i++) rx_crc[14 - i] = bits[19 + 8 * dlc_n + i];
        cap_crc_ok = (rx_crc == crc15_over(bits, 19 + 8 * dlc_n));
    endtask

    task automatic check_command(input int k);
        logic [7:0] want;
        assert (cap_id == `CAN_COMMAND_ID && cap_dlc == 4'd4)
        else log_error($sformatf("frame %0d: id %h dlc %0d", k, cap_id, cap_dlc));
        assert (cap_crc_ok) else log_error($sformatf("frame %0d: crc mismatch", k));
        for (int i = 0; i < 4; i++) begin
            want = cmd_enable ? cmd_velocity[8*i +: 8] : 8'h00;
            assert (cap_data[31 - 8*i -: 8] == want)
            else log_error($sformatf("frame %0d byte %0d: got %h, expected %h",
                                     k, i, cap_data[31 - 8*i -: 8], want));
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int prev_start;
        int kind;
        seed = SEED;
        rst_n = 1'b0;
        drive = 1'b1;
        cmd_enable = 1'b1;
        cmd_velocity = $random(seed);
        enable = cmd_enable;
        velocity = cmd_velocity;
        prev_start = 0;

        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            check_quiet("during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;  // fifth edge still sees reset.
        @(negedge clk);
        check_quiet("during reset");
        @(posedge clk);
        @(negedge clk);
        check_quiet("first cycle after reset");

        for (int k = 0; k < FRAMES; k++) begin
            capture_frame();
            check_command(k);
            if (k > 0) begin
                assert (cap_start - prev_start == PERIOD + 1)
                else log_error($sformatf("frame %0d: start spacing %0d cycles",
                                         k, cap_start - prev_start));
            end
            prev_start = cap_start;
            check_outputs($sformatf("after command frame %0d", k));

            // inputs for the next command.
            @(posedge clk);
            cmd_enable = !(k == 1 || k == 4);
            cmd_velocity = $random(seed);
            enable <= cmd_enable;
            velocity <= cmd_velocity;
            repeat (4 * BIT_CYCLES) @(posedge clk);  // interframe gap.

            case (k)
                1: kind = KIND_WRONG_ID;
                2: kind = KIND_SHORT;
                3, 6: kind = KIND_BAD_CRC;
                default: kind = KIND_VALID;
            endcase
            send_status(kind);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog.
    initial begin
        #(TIMEOUT_PERIODS * (PERIOD + 1) * CLK_NS);
        $display("timeout: the run did not finish within %0d periods", TIMEOUT_PERIODS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* design/can_drive_link.sv */
`timescale 1ns/1ps
`default_nettype none
`include "can_cfg.svh"

module can_drive_link #(
    parameter int BIT_DIVIDER = `CAN_BIT_DIVIDER,
    parameter int TX_PERIOD = `CAN_TX_PERIOD
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic rx,
    output logic tx,
    input wire logic enable,
    input wire logic [31:0] velocity,
    output logic [31:0] position,
    output logic [15:0] power,
    output logic [7:0] temp,
    output logic [3:0] state,
    output logic traj,
    output logic mot,
    output logic enc,
    output logic ctrl
);

    import can_pkg::*;

    localparam int RX_BYTES = `CAN_STATUS_BYTES;
    localparam int TX_BYTES = `CAN_COMMAND_BYTES;
    localparam can_id_t STATUS_ID = `CAN_STATUS_ID;
    localparam can_id_t COMMAND_ID = `CAN_COMMAND_ID;
    localparam int PERIOD_W = $clog2(TX_PERIOD + 1);

    logic rx_ack;
    logic tx_bit;
    logic rx_valid;
    can_id_t rx_id;
    can_dlc_t rx_dlc;
    logic [RX_BYTES*8-1:0] rx_data;
    logic [7:0] status_byte [RX_BYTES];
    logic status_hit;

    logic tx_busy;
    logic tx_start;
    logic [TX_BYTES*8-1:0] tx_data;
    logic [PERIOD_W-1:0] period_q;

    assign tx = tx_bit & rx_ack;  // open drain, either side pulls low.

    //////////////////////////////
    // status frame decode
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < RX_BYTES; i++) begin
            status_byte[i] = rx_data[RX_BYTES*8 - 1 - 8*i -: 8];  // byte 0 arrived first.
        end
    end

    assign status_hit = rx_valid && (rx_id == STATUS_ID) && (rx_dlc == can_dlc_t'(RX_BYTES));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            position <= '0;
            power <= '0;
            temp <= '0;
            state <= '0;
            traj <= 1'b0;
            mot <= 1'b0;
            enc <= 1'b0;
            ctrl <= 1'b0;
        end else if (status_hit) begin
            position <= {status_byte[3], status_byte[2], status_byte[1], status_byte[0]};
            power <= {status_byte[5], status_byte[4]};
            temp <= status_byte[6];
            traj <= status_byte[7][7];
            mot <= status_byte[7][6];
            enc <= status_byte[7][5];
            ctrl <= status_byte[7][4];
            state <= status_byte[7][3:0];
        end
    end

    //////////////////////////////
    // periodic velocity command
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            period_q <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (period_q == '0) begin
                period_q <= PERIOD_W'(TX_PERIOD);
                tx_start <= ~tx_busy;
            end else begin
                period_q <= period_q - 1'b1;
            end
        end
    end

    // least significant byte goes out first.
    always_ff @(posedge clk) begin
        if (period_q == '0) begin
            tx_data <= enable ? {velocity[7:0], velocity[15:8], velocity[23:16], velocity[31:24]}
                              : '0;
        end
    end

    can_rx #(
        .BIT_DIVIDER(BIT_DIVIDER),
        .DATA_BYTES(RX_BYTES)
    ) rx0 (
        .clk(clk),
        .rst_n(rst_n),
        .rx(rx),
        .ack(rx_ack),
        .valid(rx_valid),
        .id(rx_id),
        .dlc(rx_dlc),
        .data(rx_data)
    );

    can_tx #(
        .BIT_DIVIDER(BIT_DIVIDER),
        .DATA_BYTES(TX_BYTES)
    ) tx0 (
        .clk(clk),
        .rst_n(rst_n),
        .start(tx_start),
        .id(COMMAND_ID),
        .dlc(can_dlc_t'(TX_BYTES)),
        .data(tx_data),
        .tx(tx_bit),
        .busy(tx_busy)
    );

endmodule

`default_nettype wire

/* design/can_rx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "can_cfg.svh"

module can_rx #(
    parameter int BIT_DIVIDER = `CAN_BIT_DIVIDER,
    parameter int DATA_BYTES = `CAN_STATUS_BYTES
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic rx,
    output logic ack,
    output logic valid,
    output can_pkg::can_id_t id,
    output can_pkg::can_dlc_t dlc,
    output logic [DATA_BYTES*8-1:0] data
);

    import can_pkg::*;

    localparam int DATA_BITS = DATA_BYTES * 8;
    localparam int TIMER_W = $clog2(BIT_DIVIDER + 1);
    localparam int SAMPLE_POINT = BIT_DIVIDER / 2;

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    can_field_e field_q;  // field of the bit being received.
    logic [6:0] idx_q;
    logic [TIMER_W-1:0] timer_q;
    logic [2:0] run_q;
    logic last_q;
    logic [14:0] crc_rx_q;
    logic crc_ok_q;
    logic ack_q;
    logic valid_q;

    logic fall;
    logic sample;
    logic stuff;
    logic counted;
    logic abort;
    logic crc_clear;
    logic crc_step;
    can_dlc_t len_dlc;
    logic [6:0] data_len;
    logic [14:0] crc_calc;

    assign fall = rx_prev & ~rx_sync;
    assign sample = (field_q != FIELD_IDLE) && (timer_q == SAMPLE_POINT);

    assign stuff = sample && (run_q == 3'd5) &&
                   (field_q >= FIELD_IDENT) && (field_q <= FIELD_CRC_DELIM);
    assign counted = (field_q >= FIELD_START) && (field_q <= FIELD_CRC);

    // sixth equal bit, false start, extended frame or bad crc delimiter.
    assign abort = (stuff && (rx_sync == last_q)) ||
                   (sample && (field_q == FIELD_START) && rx_sync) ||
                   (sample && !stuff && (field_q == FIELD_IDE) && rx_sync) ||
                   (sample && !stuff && (field_q == FIELD_CRC_DELIM) && !rx_sync);

    assign crc_clear = sample && (field_q == FIELD_START);
    assign crc_step = sample && !stuff && (field_q >= FIELD_START) && (field_q <= FIELD_DATA);

    // the length field is still shifting in on its own last bit.
    assign len_dlc = (field_q == FIELD_LENGTH) ? {dlc[2:0], rx_sync} : dlc;
    assign data_len = (len_dlc > 4'd8) ? 7'd64 : {len_dlc, 3'b000};

    //////////////////////////////
    // bit timing and fields
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
            field_q <= FIELD_IDLE;
            idx_q <= '0;
            timer_q <= '0;
            run_q <= '0;
            last_q <= 1'b1;
            crc_ok_q <= 1'b0;
            ack_q <= 1'b1;
            valid_q <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
            valid_q <= 1'b0;

            // our own ack edge must not shift the bit timing.
            if (fall && (field_q != FIELD_ACK_SLOT)) begin
                timer_q <= '0;
            end else if (timer_q == BIT_DIVIDER - 1) begin
                timer_q <= '0;
            end else begin
                timer_q <= timer_q + 1'b1;
            end

            if (timer_q == BIT_DIVIDER - 1) begin
                ack_q <= !((field_q == FIELD_ACK_SLOT) && crc_ok_q);  // one bit time.
            end

            if (field_q == FIELD_IDLE) begin
                if (fall) begin
                    field_q <= FIELD_START;  // hard sync.
                    idx_q <= '0;
                end
            end else if (sample) begin
                if (abort) begin
                    field_q <= FIELD_IDLE;
                end else if (stuff) begin
                    run_q <= 3'd1;
                    last_q <= rx_sync;
                end else begin
                    if (counted) begin
                        if ((field_q == FIELD_START) || (rx_sync != last_q)) begin
                            run_q <= 3'd1;
                        end else begin
                            run_q <= run_q + 3'd1;
                        end
                        last_q <= rx_sync;
                    end
                    if (field_q == FIELD_CRC_DELIM) begin
                        crc_ok_q <= (crc_rx_q == crc_calc);
                    end
                    if (field_q == FIELD_ACK_DELIM) begin
                        valid_q <= crc_ok_q;
                    end
                    if (idx_q == can_field_last(field_q, data_len)) begin
                        field_q <= can_field_next(field_q, data_len != 7'd0);
                        idx_q <= '0;
                    end else begin
                        idx_q <= idx_q + 7'd1;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (crc_clear) begin
            id <= '0;
            dlc <= '0;
            data <= '0;  // bytes past dlc stay zero.
        end else if (sample && !stuff) begin
            case (field_q)
                FIELD_IDENT: id <= {id[9:0], rx_sync};
                FIELD_LENGTH: dlc <= {dlc[2:0], rx_sync};
                FIELD_DATA: begin
                    if (idx_q < DATA_BITS) begin
                        data[DATA_BITS - 1 - idx_q] <= rx_sync;
                    end
                end
                FIELD_CRC: crc_rx_q <= {crc_rx_q[13:0], rx_sync};
                default: ;
            endcase
        end
    end

    can_crc15 crc0 (
        .clk(clk),
        .rst_n(rst_n),
        .clear(crc_clear),
        .step(crc_step),
        .bit_value(rx_sync),
        .crc(crc_calc)
    );

    assign ack = ack_q;
    assign valid = valid_q;

endmodule

`default_nettype wire

/* design/can_tx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "can_cfg.svh"

module can_tx #(
    parameter int BIT_DIVIDER = `CAN_BIT_DIVIDER,
    parameter int DATA_BYTES = `CAN_COMMAND_BYTES
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic start,
    input wire can_pkg::can_id_t id,
    input wire can_pkg::can_dlc_t dlc,
    input wire logic [DATA_BYTES*8-1:0] data,
    output logic tx,
    output logic busy
);

    import can_pkg::*;

    localparam int DATA_BITS = DATA_BYTES * 8;
    localparam int TIMER_W = $clog2(BIT_DIVIDER + 1);

    can_id_t id_q;
    can_dlc_t dlc_q;
    logic [DATA_BITS-1:0] data_q;

    can_field_e field_q;  // field of the next bit to send.
    logic [6:0] idx_q;
    logic [TIMER_W-1:0] timer_q;
    logic [2:0] run_q;
    logic last_q;
    logic tx_q;
    logic busy_q;

    logic accept;
    logic boundary;
    logic stuff;
    logic counted;
    logic cur_bit;
    logic crc_step;
    logic crc_bit;
    logic [6:0] data_len;
    logic [14:0] crc;

    assign accept = start & ~busy_q;
    assign boundary = busy_q && (timer_q == BIT_DIVIDER - 1);
    assign data_len = (dlc_q > DATA_BYTES) ? 7'(DATA_BITS) : {dlc_q, 3'b000};

    // five equal bits force a stuff bit, up to and including the bit after the crc.
    assign stuff = boundary && (run_q == 3'd5) &&
                   (field_q >= FIELD_IDENT) && (field_q <= FIELD_CRC_DELIM);
    assign counted = (field_q >= FIELD_IDENT) && (field_q <= FIELD_CRC);

    assign crc_step = accept ||
                      (boundary && !stuff && (field_q >= FIELD_IDENT) && (field_q <= FIELD_DATA));
    assign crc_bit = accept ? 1'b0 : cur_bit;

    always_comb begin
        case (field_q)
            FIELD_START, FIELD_RTR, FIELD_IDE, FIELD_RESERVED: cur_bit = 1'b0;
            FIELD_IDENT: cur_bit = id_q[4'd10 - idx_q[3:0]];
            FIELD_LENGTH: cur_bit = dlc_q[2'd3 - idx_q[1:0]];
            FIELD_DATA: cur_bit = data_q[DATA_BITS - 1 - idx_q];  // first byte on top.
            FIELD_CRC: cur_bit = crc[4'd14 - idx_q[3:0]];
            default: cur_bit = 1'b1;  // delimiters, ack slot and eof are recessive.
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_q <= id;
            dlc_q <= dlc;
            data_q <= data;
        end
    end

    //////////////////////////////
    // bit sequencer
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            field_q <= FIELD_IDLE;
            idx_q <= '0;
            timer_q <= '0;
            run_q <= '0;
            last_q <= 1'b1;
            tx_q <= 1'b1;
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
            timer_q <= '0;
            tx_q <= 1'b0;  // start of frame.
            run_q <= 3'd1;
            last_q <= 1'b0;
            field_q <= FIELD_IDENT;
            idx_q <= '0;
        end else if (busy_q) begin
            timer_q <= (timer_q == BIT_DIVIDER - 1) ? '0 : timer_q + 1'b1;
            if (boundary) begin
                if (field_q == FIELD_IDLE) begin
                    busy_q <= 1'b0;  // last eof bit has finished.
                end else if (stuff) begin
                    tx_q <= ~last_q;
                    last_q <= ~last_q;
                    run_q <= 3'd1;
                end else begin
                    tx_q <= cur_bit;
                    if (counted) begin
                        run_q <= (cur_bit == last_q) ? run_q + 3'd1 : 3'd1;
                        last_q <= cur_bit;
                    end
                    if (idx_q == can_field_last(field_q, data_len)) begin
                        field_q <= can_field_next(field_q, data_len != 7'd0);
                        idx_q <= '0;
                    end else begin
                        idx_q <= idx_q + 7'd1;
                    end
                end
            end
        end
    end

    can_crc15 crc0 (
        .clk(clk),
        .rst_n(rst_n),
        .clear(accept),
        .step(crc_step),
        .bit_value(crc_bit),
        .crc(crc)
    );

    assign tx = tx_q;
    assign busy = busy_q;

endmodule

`default_nettype wire

/* design/can_crc15.sv */
`timescale 1ns/1ps
`default_nettype none

module can_crc15 (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic clear,
    input wire logic step,
    input wire logic bit_value,
    output logic [14:0] crc
);

    localparam logic [14:0] CRC_POLY = 15'h4599;

    logic [14:0] base;
    logic [14:0] shifted;
    logic feedback;

    // clear and step together start a new remainder with the first bit.
    always_comb begin
        base = clear ? 15'd0 : crc;
        feedback = bit_value ^ base[14];
        shifted = {base[13:0], 1'b0};
        if (feedback) begin
            shifted = shifted ^ CRC_POLY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crc <= '0;
        end else if (step) begin
            crc <= shifted;
        end else if (clear) begin
            crc <= '0;
        end
    end

endmodule

`default_nettype wire

/* design/can_pkg.sv */
`default_nettype none

package can_pkg;

    typedef logic [10:0] can_id_t;  // standard identifier only.
    typedef logic [3:0] can_dlc_t;

    // position of the bit sequencer within a data frame.
    typedef enum logic [3:0] {
        FIELD_IDLE,
        FIELD_START,
        FIELD_IDENT,
        FIELD_RTR,
        FIELD_IDE,
        FIELD_RESERVED,
        FIELD_LENGTH,
        FIELD_DATA,
        FIELD_CRC,
        FIELD_CRC_DELIM,
        FIELD_ACK_SLOT,
        FIELD_ACK_DELIM,
        FIELD_EOF
    } can_field_e;

    // index of the last bit in a field, data_len counts data bits.
    function automatic logic [6:0] can_field_last(can_field_e field, logic [6:0] data_len);
        case (field)
            FIELD_IDENT: return 7'd10;
            FIELD_LENGTH: return 7'd3;
            FIELD_DATA: return data_len - 7'd1;
            FIELD_CRC: return 7'd14;
            FIELD_EOF: return 7'd6;
            default: return 7'd0;
        endcase
    endfunction

    // field order of a standard data frame.
    function automatic can_field_e can_field_next(can_field_e field, logic has_data);
        case (field)
            FIELD_START: return FIELD_IDENT;
            FIELD_IDENT: return FIELD_RTR;
            FIELD_RTR: return FIELD_IDE;
            FIELD_IDE: return FIELD_RESERVED;
            FIELD_RESERVED: return FIELD_LENGTH;
            FIELD_LENGTH: return has_data ? FIELD_DATA : FIELD_CRC;  // zero length skips data.
            FIELD_DATA: return FIELD_CRC;
            FIELD_CRC: return FIELD_CRC_DELIM;
            FIELD_CRC_DELIM: return FIELD_ACK_SLOT;
            FIELD_ACK_SLOT: return FIELD_ACK_DELIM;
            FIELD_ACK_DELIM: return FIELD_EOF;
            default: return FIELD_IDLE;
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/can_cfg.svh */
`ifndef CAN_CFG_SVH
`define CAN_CFG_SVH

//////////////////////////////
// bit timing
//////////////////////////////

// clock cycles per bit time.
`define CAN_BIT_DIVIDER 53

// reload value of the command period counter.
`define CAN_TX_PERIOD 53000

//////////////////////////////
// frame layout
//////////////////////////////

`define CAN_STATUS_ID 11'h01E   // status frame from the drive.
`define CAN_COMMAND_ID 11'h00D  // velocity command to the drive.

`define CAN_STATUS_BYTES 8
`define CAN_COMMAND_BYTES 4

`endif
